// File: Bender.yml
package:
  name: mipsCore

sources:
  - files:
      - logic/mipsPkg.sv
      - logic/decoder.sv
      - logic/regFile.sv
      - logic/alu.sv
      - logic/hazardUnit.sv
      - logic/memAlign.sv
      - logic/mipsCore.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/mipsCoreTb.sv

// File: logic/alu.sv
`timescale 1ns/10ps

module alu import mipsPkg::*; (
    input  logic [dataWidth-1:0]    srcA,
    input  logic [dataWidth-1:0]    srcB,
    input  logic [regAddrWidth-1:0] shamt,
    input  aluOpT                   aluOp,
    output logic [dataWidth-1:0]    result,
    output logic                    equal
);
    logic lessThan;

    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluOp)
            aluAdd:  result = srcA + srcB;     // wraps, no overflow trap
            aluSub:  result = srcA - srcB;
            aluAnd:  result = srcA & srcB;
            aluOr:   result = srcA | srcB;
            aluXor:  result = srcA ^ srcB;
            aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
            aluSll:  result = srcB << shamt;
            aluLui:  result = {srcB[15:0], 16'b0};
            default: result = '0;
        endcase
    end

    // branch compare, operands already forwarded
    assign equal = srcA == srcB;

endmodule

// File: logic/decoder.sv
`timescale 1ns/10ps

module decoder import mipsPkg::*; (
    input  logic [dataWidth-1:0]    instr,
    output logic [regAddrWidth-1:0] rs,
    output logic [regAddrWidth-1:0] rt,
    output logic [regAddrWidth-1:0] rd,
    output logic [regAddrWidth-1:0] shamt,
    output logic [dataWidth-1:0]    imm,
    output aluOpT                   aluOp,
    output logic                    aluSrcImm,
    output logic                    regDst,
    output logic                    regWrite,
    output logic                    memRead,
    output logic                    memWrite,
    output logic                    loadUnsigned,
    output logic                    branch,
    output logic                    branchNe,
    output memSizeT                 memSize
);
    logic [5:0]              opcode;
    logic [5:0]              funct;
    logic                    writes;    // produces a register result
    logic                    zeroExt;
    logic [regAddrWidth-1:0] dest;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];

    // only the logical immediates are zero extended
    assign zeroExt = (opcode == opAndi) || (opcode == opOri);
    assign imm = zeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    assign dest     = regDst ? rd : rt;
    assign regWrite = writes && (dest != '0);   // r0 writes dropped here

    // size and signedness sit in the low opcode bits of loads and stores
    assign loadUnsigned = memRead && opcode[2];
    assign memSize = (opcode[1:0] == 2'b11) ? sizeWord : (opcode[0] ? sizeHalf : sizeByte);

    always_comb begin
        aluOp     = aluAdd;
        aluSrcImm = 1'b0;
        regDst    = 1'b0;
        writes    = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        branchNe  = 1'b0;
        case (opcode)
            opSpecial: begin
                regDst = 1'b1;
                writes = 1'b1;
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd:  aluOp = aluAnd;
                    fnOr:   aluOp = aluOr;
                    fnXor:  aluOp = aluXor;
                    fnSlt:  aluOp = aluSlt;
                    fnSll:  aluOp = aluSll;
                    default: begin
                        regDst = 1'b0;
                        writes = 1'b0;
                    end
                endcase
            end
            opAddiu: begin
                writes    = 1'b1;
                aluSrcImm = 1'b1;
            end
            opAndi: begin
                writes    = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = aluAnd;
            end
            opOri: begin
                writes    = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = aluOr;
            end
            opLui: begin
                writes    = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = aluLui;
            end
            opBeq: branch = 1'b1;
            opBne: begin
                branch   = 1'b1;
                branchNe = 1'b1;
            end
            opLw, opLh, opLhu, opLb, opLbu: begin
                writes    = 1'b1;
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
            end
            opSw, opSh, opSb: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
            end
            default: ;  // unknown encodings retire as no-ops
        endcase
    end

endmodule

// File: logic/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit import mipsPkg::*; (
    input  logic [regAddrWidth-1:0] rsD,
    input  logic [regAddrWidth-1:0] rtD,
    input  logic [regAddrWidth-1:0] rsE,
    input  logic [regAddrWidth-1:0] rtE,
    input  logic [regAddrWidth-1:0] wregE,
    input  logic [regAddrWidth-1:0] wregM,
    input  logic [regAddrWidth-1:0] wregW,
    input  logic                    memReadE,
    input  logic                    regWriteM,
    input  logic                    memReadM,
    input  logic                    regWriteW,
    output fwdSelT                  fwdA,
    output fwdSelT                  fwdB,
    output logic                    loadUseStall
);

    // memory stage wins over writeback, a load in memory has no data yet
    function automatic fwdSelT pickSource(logic [regAddrWidth-1:0] src);
        if (src == '0)
            return fwdRf;
        if (regWriteM && !memReadM && wregM == src)
            return fwdMem;
        if (regWriteW && wregW == src)
            return fwdWb;
        return fwdRf;
    endfunction

    always_comb begin
        fwdA = pickSource(rsE);
        fwdB = pickSource(rtE);
    end

    // rt compared even for i-type, a spare stall costs nothing
    assign loadUseStall = memReadE && wregE != '0 && (wregE == rsD || wregE == rtD);

endmodule

// File: logic/memAlign.sv
`timescale 1ns/10ps

module memAlign import mipsPkg::*; (
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic                 loadUnsigned,
    input  memSizeT              memSize,
    input  logic [1:0]           addrLow,
    input  logic [dataWidth-1:0] storeData,
    input  logic [dataWidth-1:0] rdata,
    output logic [3:0]           wen,
    output logic [dataWidth-1:0] wdata,
    output logic [dataWidth-1:0] loadData
);
    logic [7:0]  byteSel;
    logic [15:0] halfSel;

    // store side, data copied to every lane and only the strobes pick
    always_comb begin
        wen   = 4'b0000;
        wdata = storeData;
        if (memWrite) begin
            case (memSize)
                sizeByte: begin
                    wen   = 4'b0001 << addrLow;
                    wdata = {4{storeData[7:0]}};
                end
                sizeHalf: begin
                    wen   = addrLow[1] ? 4'b1100 : 4'b0011;
                    wdata = {2{storeData[15:0]}};
                end
                default: wen = 4'b1111;
            endcase
        end
    end

    assign byteSel = rdata[8*addrLow +: 8];
    assign halfSel = addrLow[1] ? rdata[31:16] : rdata[15:0];   // addrLow[0] ignored

    always_comb begin
        loadData = '0;
        if (memRead) begin
            case (memSize)
                sizeByte: loadData = {{24{byteSel[7] & ~loadUnsigned}}, byteSel};
                sizeHalf: loadData = {{16{halfSel[15] & ~loadUnsigned}}, halfSel};
                default:  loadData = rdata;
            endcase
        end
    end

endmodule

// File: logic/mipsCore.sv
`timescale 1ns/10ps

module mipsCore import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    output logic [dataWidth-1:0]    instrAddr,
    input  logic [dataWidth-1:0]    instr,
    input  logic                    iStall,
    input  logic                    dStall,
    output logic                    memEn,
    output logic [dataWidth-1:0]    dataAddr,
    output logic [3:0]              dataWen,
    output logic [dataWidth-1:0]    dataWdata,
    input  logic [dataWidth-1:0]    dataRdata,
    output logic [dataWidth-1:0]    debugWbPc,
    output logic [3:0]              debugWbRfWen,
    output logic [regAddrWidth-1:0] debugWbRfWnum,
    output logic [dataWidth-1:0]    debugWbRfWdata
);
    logic                    stallAll;
    logic                    loadUseStall;
    logic                    branchTaken;
    logic [dataWidth-1:0]    pc;
    logic [dataWidth-1:0]    branchTarget;

    // decode
    logic [dataWidth-1:0]    instrD, pcD, immD, rd1D, rd2D;
    logic [regAddrWidth-1:0] rsD, rtD, rdD, shamtD, wregD;
    aluOpT                   aluOpD;
    memSizeT                 memSizeD;
    logic                    aluSrcImmD, regDstD, regWriteD, memReadD, memWriteD;
    logic                    loadUnsignedD, branchD, branchNeD;

    // execute
    logic [dataWidth-1:0]    pcE, immE, rd1E, rd2E;
    logic [regAddrWidth-1:0] rsE, rtE, shamtE, wregE;
    aluOpT                   aluOpE;
    memSizeT                 memSizeE;
    logic                    aluSrcImmE, regWriteE, memReadE, memWriteE;
    logic                    loadUnsignedE, branchE, branchNeE;
    fwdSelT                  fwdA, fwdB;
    logic [dataWidth-1:0]    srcA, srcBReg, srcB, aluResultE;
    logic                    equalE;

    // memory
    logic [dataWidth-1:0]    pcM, aluM, storeDataM, loadDataM;
    logic [regAddrWidth-1:0] wregM;
    memSizeT                 memSizeM;
    logic                    regWriteM, memReadM, memWriteM, loadUnsignedM;

    // writeback
    logic [dataWidth-1:0]    pcW, aluW, loadW, resultW;
    logic [regAddrWidth-1:0] wregW;
    logic                    regWriteW, memToRegW, rfWen;

    function automatic logic [dataWidth-1:0] fwdPick(fwdSelT sel,
                                                     logic [dataWidth-1:0] rfValue,
                                                     logic [dataWidth-1:0] memValue,
                                                     logic [dataWidth-1:0] wbValue);
        case (sel)
            fwdMem:  return memValue;
            fwdWb:   return wbValue;
            default: return rfValue;
        endcase
    endfunction

    assign stallAll  = iStall | dStall;
    assign instrAddr = pc;

    // fetch
    assign branchTaken  = branchE & (equalE ^ branchNeE);
    assign branchTarget = pcE + 32'd4 + {immE[dataWidth-3:0], 2'b00};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else if (!stallAll && !loadUseStall) begin
            pc <= branchTaken ? branchTarget : pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instrD <= '0;   // decodes as a no-op
        end else if (!stallAll) begin
            if (branchTaken) begin
                instrD <= '0;   // kill the word after the delay slot
            end else if (!loadUseStall) begin
                instrD <= instr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stallAll && !loadUseStall) begin
            pcD <= pc;
        end
    end

    // decode
    decoder uDecoder (
        .instr        (instrD),
        .rs           (rsD),
        .rt           (rtD),
        .rd           (rdD),
        .shamt        (shamtD),
        .imm          (immD),
        .aluOp        (aluOpD),
        .aluSrcImm    (aluSrcImmD),
        .regDst       (regDstD),
        .regWrite     (regWriteD),
        .memRead      (memReadD),
        .memWrite     (memWriteD),
        .loadUnsigned (loadUnsignedD),
        .branch       (branchD),
        .branchNe     (branchNeD),
        .memSize      (memSizeD)
    );

    assign wregD = regDstD ? rdD : rtD;

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .wen    (rfWen),
        .waddr  (wregW),
        .wdata  (resultW),
        .raddr1 (rsD),
        .raddr2 (rtD),
        .rdata1 (rd1D),
        .rdata2 (rd2D)
    );

    hazardUnit uHazard (
        .rsD          (rsD),
        .rtD          (rtD),
        .rsE          (rsE),
        .rtE          (rtE),
        .wregE        (wregE),
        .wregM        (wregM),
        .wregW        (wregW),
        .memReadE     (memReadE),
        .regWriteM    (regWriteM),
        .memReadM     (memReadM),
        .regWriteW    (regWriteW),
        .fwdA         (fwdA),
        .fwdB         (fwdB),
        .loadUseStall (loadUseStall)
    );

    // a load-use stall sends a bubble into execute
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteE <= 1'b0;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            branchE   <= 1'b0;
        end else if (!stallAll) begin
            regWriteE <= regWriteD & ~loadUseStall;
            memReadE  <= memReadD & ~loadUseStall;
            memWriteE <= memWriteD & ~loadUseStall;
            branchE   <= branchD & ~loadUseStall;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallAll) begin
            pcE           <= pcD;
            immE          <= immD;
            rd1E          <= rd1D;
            rd2E          <= rd2D;
            rsE           <= rsD;
            rtE           <= rtD;
            shamtE        <= shamtD;
            wregE         <= wregD;
            aluOpE        <= aluOpD;
            memSizeE      <= memSizeD;
            aluSrcImmE    <= aluSrcImmD;
            loadUnsignedE <= loadUnsignedD;
            branchNeE     <= branchNeD;
        end
    end

    // execute
    assign srcA    = fwdPick(fwdA, rd1E, aluM, resultW);
    assign srcBReg = fwdPick(fwdB, rd2E, aluM, resultW);   // also the store data
    assign srcB    = aluSrcImmE ? immE : srcBReg;

    alu uAlu (
        .srcA   (srcA),
        .srcB   (srcB),
        .shamt  (shamtE),
        .aluOp  (aluOpE),
        .result (aluResultE),
        .equal  (equalE)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
        end else if (!stallAll) begin
            regWriteM <= regWriteE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallAll) begin
            pcM           <= pcE;
            aluM          <= aluResultE;
            storeDataM    <= srcBReg;
            wregM         <= wregE;
            memSizeM      <= memSizeE;
            loadUnsignedM <= loadUnsignedE;
        end
    end

    // memory
    assign memEn    = memReadM | memWriteM;
    assign dataAddr = aluM;

    memAlign uMemAlign (
        .memRead      (memReadM),
        .memWrite     (memWriteM),
        .loadUnsigned (loadUnsignedM),
        .memSize      (memSizeM),
        .addrLow      (aluM[1:0]),
        .storeData    (storeDataM),
        .rdata        (dataRdata),
        .wen          (dataWen),
        .wdata        (dataWdata),
        .loadData     (loadDataM)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else if (!stallAll) begin
            regWriteW <= regWriteM;
            memToRegW <= memReadM;
        end
    end

    always_ff @(posedge clk) begin
        if (!stallAll) begin
            pcW   <= pcM;
            aluW  <= aluM;
            loadW <= loadDataM;
            wregW <= wregM;
        end
    end

    // writeback, a frozen cycle neither writes nor reports
    assign resultW = memToRegW ? loadW : aluW;
    assign rfWen   = regWriteW & ~stallAll;

    assign debugWbPc      = pcW;
    assign debugWbRfWen   = {4{rfWen}};
    assign debugWbRfWnum  = wregW;
    assign debugWbRfWdata = resultW;

endmodule

// File: logic/mipsPkg.sv
package mipsPkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam logic [31:0] resetPc = 32'h0000_0000;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        sizeByte,
        sizeHalf,
        sizeWord
    } memSizeT;

    // where an execute operand comes from
    typedef enum logic [1:0] {
        fwdRf,
        fwdMem,
        fwdWb
    } fwdSelT;

    // primary opcodes, instr[31:26]
    localparam logic [5:0] opSpecial = 6'b000000;
    localparam logic [5:0] opAddiu   = 6'b001001;
    localparam logic [5:0] opAndi    = 6'b001100;
    localparam logic [5:0] opOri     = 6'b001101;
    localparam logic [5:0] opLui     = 6'b001111;
    localparam logic [5:0] opBeq     = 6'b000100;
    localparam logic [5:0] opBne     = 6'b000101;
    localparam logic [5:0] opLw      = 6'b100011;
    localparam logic [5:0] opLh      = 6'b100001;
    localparam logic [5:0] opLhu     = 6'b100101;
    localparam logic [5:0] opLb      = 6'b100000;
    localparam logic [5:0] opLbu     = 6'b100100;
    localparam logic [5:0] opSw      = 6'b101011;
    localparam logic [5:0] opSh      = 6'b101001;
    localparam logic [5:0] opSb      = 6'b101000;

    // function field of special, instr[5:0]
    localparam logic [5:0] fnAddu = 6'b100001;
    localparam logic [5:0] fnSubu = 6'b100011;
    localparam logic [5:0] fnAnd  = 6'b100100;
    localparam logic [5:0] fnOr   = 6'b100101;
    localparam logic [5:0] fnXor  = 6'b100110;
    localparam logic [5:0] fnSlt  = 6'b101010;
    localparam logic [5:0] fnSll  = 6'b000000;

endpackage

// File: logic/regFile.sv
`timescale 1ns/10ps

module regFile import mipsPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    wen,
    input  logic [regAddrWidth-1:0] waddr,
    input  logic [dataWidth-1:0]    wdata,
    input  logic [regAddrWidth-1:0] raddr1,
    input  logic [regAddrWidth-1:0] raddr2,
    output logic [dataWidth-1:0]    rdata1,
    output logic [dataWidth-1:0]    rdata2
);
    logic [dataWidth-1:0] regs [1:2**regAddrWidth-1];   // no storage for r0

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write shows through to the read
    function automatic logic [dataWidth-1:0] readPort(logic [regAddrWidth-1:0] addr);
        if (addr == '0)
            return '0;
        if (wen && waddr == addr)
            return wdata;
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = readPort(raddr1);
        rdata2 = readPort(raddr2);
    end

endmodule

// File: mipsCore.f
logic/mipsPkg.sv
logic/decoder.sv
logic/regFile.sv
logic/alu.sv
logic/hazardUnit.sv
logic/memAlign.sv
logic/mipsCore.sv
sim/clockGen.sv
sim/mipsCoreTb.sv

// File: sim/clockGen.sv
`timescale 1ns/10ps

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // held low through three rising edges, released on a falling edge
    initial begin
        arstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// File: sim/mipsCoreTb.sv
`timescale 1ns/10ps

module mipsCoreTb import mipsPkg::*; ();

    localparam int memWords = 64;      // 256 bytes of data memory
    localparam int progMax  = 128;

    logic        clk;
    logic        arstN;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic        iStall;
    logic        dStall;
    logic        memEn;
    logic [31:0] dataAddr;
    logic [3:0]  dataWen;
    logic [31:0] dataWdata;
    logic [31:0] dataRdata;
    logic [31:0] debugWbPc;
    logic [3:0]  debugWbRfWen;
    logic [4:0]  debugWbRfWnum;
    logic [31:0] debugWbRfWdata;

    logic [31:0] imem [0:progMax-1];
    logic [31:0] dataMem [0:memWords-1];
    int          progLen;
    integer      seed = 11;
    logic        done;

    // shadow machine state
    logic [31:0] refRegs [0:31];
    logic [31:0] refMem [0:memWords-1];
    logic [31:0] refPc;
    logic [31:0] refNextPc;        // holds the branch target across the delay slot

    clockGen clkGen (
        .clk   (clk),
        .arstN (arstN)
    );

    mipsCore uut (
        .clk            (clk),
        .arstN          (arstN),
        .instrAddr      (instrAddr),
        .instr          (instr),
        .iStall         (iStall),
        .dStall         (dStall),
        .memEn          (memEn),
        .dataAddr       (dataAddr),
        .dataWen        (dataWen),
        .dataWdata      (dataWdata),
        .dataRdata      (dataRdata),
        .debugWbPc      (debugWbPc),
        .debugWbRfWen   (debugWbRfWen),
        .debugWbRfWnum  (debugWbRfWnum),
        .debugWbRfWdata (debugWbRfWdata)
    );

    // past the program the fetch sees nops
    always_comb begin
        if (instrAddr[31:2] < progLen)
            instr = imem[instrAddr[8:2]];
        else
            instr = 32'h0000_0000;
    end

    // read data only while the core says an access is under way
    assign dataRdata = memEn ? dataMem[dataAddr[7:2]] : 'x;

    function automatic logic [31:0] mergeLanes(logic [31:0] old, logic [31:0] data,
                                               logic [3:0] strobes);
        logic [31:0] merged;
        merged = old;
        for (int l = 0; l < 4; l++) begin
            if (strobes[l])
                merged[8*l +: 8] = data[8*l +: 8];
        end
        return merged;
    endfunction

    always @(posedge clk) begin
        if (dataWen != 4'b0000) begin
            checkEq("memEn", memEn, 32'h1);
            dataMem[dataAddr[7:2]] <= mergeLanes(dataMem[dataAddr[7:2]], dataWdata,
                                                 dataWen);
        end
    end

    function automatic logic [31:0] fillWord(int i);
        return (i * 32'h9E37_79B1) ^ 32'hA5C3_0F00;
    endfunction

    task automatic failRun(string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            failRun($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, expected));
        end
    endtask

    task automatic emitR(logic [5:0] fn, int rd, int rs, int rt, int sh);
        imem[progLen] = {opSpecial, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
        progLen++;
    endtask

    task automatic emitI(logic [5:0] op, int rt, int rs, int imm);
        imem[progLen] = {op, rs[4:0], rt[4:0], imm[15:0]};
        progLen++;
    endtask

    task automatic loadConst(int r, logic [31:0] value);
        emitI(opLui, r, 0, {16'h0, value[31:16]});
        emitI(opOri, r, r, {16'h0, value[15:0]});
    endtask

    // runs one instruction on the shadow state and tells whether it wrote a register
    function automatic logic refStep(output logic [31:0] pcOut, output logic [4:0] wnum,
                                     output logic [31:0] wdata);
        logic [31:0] word, a, b, simm, zimm, addr, w, res;
        logic [7:0]  bt;
        logic [15:0] hf;
        logic        writes;
        pcOut     = refPc;
        word      = (refPc[31:2] < progLen) ? imem[refPc[8:2]] : 32'h0;
        refPc     = refNextPc;              // delay slot comes next
        refNextPc = refNextPc + 32'd4;
        a    = refRegs[word[25:21]];
        b    = refRegs[word[20:16]];
        simm = {{16{word[15]}}, word[15:0]};
        zimm = {16'h0, word[15:0]};
        addr = a + simm;
        w    = refMem[addr[7:2]];
        bt   = w[8*addr[1:0] +: 8];
        hf   = addr[1] ? w[31:16] : w[15:0];
        res    = 32'h0;
        wnum   = word[20:16];
        writes = 1'b1;
        case (word[31:26])
            opSpecial: begin
                wnum = word[15:11];
                case (word[5:0])
                    fnAddu:  res = a + b;
                    fnSubu:  res = a - b;
                    fnAnd:   res = a & b;
                    fnOr:    res = a | b;
                    fnXor:   res = a ^ b;
                    fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fnSll:   res = b << word[10:6];
                    default: writes = 1'b0;
                endcase
            end
            opAddiu: res = a + simm;
            opAndi:  res = a & zimm;
            opOri:   res = a | zimm;
            opLui:   res = {word[15:0], 16'h0};
            opLw:    res = w;
            opLh:    res = {{16{hf[15]}}, hf};
            opLhu:   res = {16'h0, hf};
            opLb:    res = {{24{bt[7]}}, bt};
            opLbu:   res = {24'h0, bt};
            opBeq, opBne: begin
                writes = 1'b0;
                if ((a == b) == (word[31:26] == opBeq))
                    refNextPc = pcOut + 32'd4 + (simm << 2);
            end
            opSw, opSh, opSb: begin
                writes = 1'b0;
                if (word[31:26] == opSw)
                    w = b;
                else if (word[31:26] == opSh && addr[1])
                    w[31:16] = b[15:0];
                else if (word[31:26] == opSh)
                    w[15:0] = b[15:0];
                else
                    w[8*addr[1:0] +: 8] = b[7:0];
                refMem[addr[7:2]] = w;
            end
            default: writes = 1'b0;         // unknown words are nops
        endcase
        wdata = res;
        if (writes && wnum != 5'd0) begin
            refRegs[wnum] = res;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic buildProgram();
        loadConst(1, $random(seed));
        loadConst(2, $random(seed));
        loadConst(3, $random(seed));
        emitR(fnAddu, 4, 1, 2, 0);
        emitR(fnSubu, 5, 4, 1, 0);      // operand from memory stage
        emitR(fnAnd, 6, 4, 5, 0);       // one from memory, one from writeback
        emitR(fnOr, 7, 6, 2, 0);
        emitR(fnXor, 8, 7, 4, 0);
        emitR(fnSlt, 9, 1, 2, 0);
        emitR(fnSlt, 10, 2, 1, 0);
        emitR(fnSll, 11, 0, 8, 7);
        emitR(fnAddu, 0, 1, 2, 0);      // r0 target retires silently
        emitI(opAddiu, 12, 11, -3);
        emitI(opAndi, 13, 12, 'h8f0f);  // zero extended
        emitI(opOri, 14, 13, 'hf0f0);
        emitI(opLui, 15, 0, 'h8001);
        emitI(opAddiu, 16, 15, 'h7fff);
        emitI(opAddiu, 16, 16, 'h8000);
        emitI(opOri, 20, 0, 'h40);      // data base address
        emitI(opSw, 1, 20, 0);
        emitI(opSw, 2, 20, 4);
        emitI(opSb, 3, 20, 1);
        emitI(opSb, 4, 20, 6);
        emitI(opSh, 5, 20, 2);
        emitI(opSh, 6, 20, 8);
        emitI(opSw, 7, 20, 12);
        emitI(opSb, 8, 20, 15);
        emitI(opSb, 9, 20, 20);
        emitI(opLw, 21, 20, 0);
        emitR(fnAddu, 22, 21, 1, 0);    // load-use
        emitI(opLb, 23, 20, 1);
        emitI(opLbu, 24, 20, 6);
        emitR(fnSubu, 25, 23, 24, 0);
        emitI(opLh, 26, 20, 2);
        emitI(opLhu, 27, 20, 6);
        emitI(opLh, 28, 20, 8);
        emitI(opLbu, 29, 20, 15);
        emitR(fnXor, 30, 29, 28, 0);
        emitI(opLw, 17, 20, 12);
        emitI(opSw, 17, 20, 16);        // loaded word straight into store data
        emitI(opBeq, 1, 1, 2);          // taken
        emitI(opAddiu, 18, 0, 1);       // delay slot
        emitI(opAddiu, 18, 0, 99);      // squashed
        emitI(opOri, 19, 18, 'h10);
        emitI(opBne, 1, 1, 5);          // not taken
        emitI(opAddiu, 18, 18, 2);
        emitI(opAddiu, 19, 19, 3);
        emitI(opLw, 21, 20, 16);
        emitI(opBeq, 17, 21, 2);        // load feeding a taken branch
        emitI(opAddiu, 3, 3, 5);
        emitI(opAddiu, 3, 3, 100);
        emitI(opAddiu, 3, 3, 7);
        emitI(opBne, 2, 1, 2);
        emitI(opAddiu, 4, 4, 1);
        emitI(opAddiu, 4, 4, 64);
        emitI(opAddiu, 10, 0, 3);
        emitI(opAddiu, 10, 10, -1);     // loop top
        emitI(opBne, 0, 10, -2);
        emitR(fnAddu, 11, 11, 10, 0);   // delay slot on every pass
        emitI(opAddiu, 12, 12, 1);      // squashed while the loop runs
        emitI(opSh, 12, 20, 22);
        emitI(opSb, 11, 20, 27);
        emitI(opLhu, 5, 20, 22);
        emitI(opAddiu, 31, 5, 1);       // end marker
    endtask

    always @(negedge clk) begin
        iStall = ($random(seed) & 7) == 0;
        dStall = ($random(seed) & 7) == 0;
    end

    // writebacks matched in program order
    always @(posedge clk) begin : compareWb
        logic [31:0] expPc;
        logic [31:0] expData;
        logic [4:0]  expNum;
        logic        found;
        if (arstN && debugWbRfWen != 4'b0000) begin
            found = 1'b0;
            while (!found && refPc[31:2] < progLen) begin
                found = refStep(expPc, expNum, expData);
            end
            if (done || !found) begin
                failRun("the DUT reported a writeback that the program does not make");
            end else begin
                checkEq("debugWbRfWen", debugWbRfWen, 32'hf);
                checkEq("debugWbPc", debugWbPc, expPc);
                checkEq("debugWbRfWnum", debugWbRfWnum, expNum);
                checkEq("debugWbRfWdata", debugWbRfWdata, expData);
                if (expPc[31:2] == progLen - 1)
                    done = 1'b1;
            end
        end
    end

    initial begin
        #1;     // program is built at time zero
        repeat (progLen * 8) @(posedge clk);
        failRun("the run timed out before the last instruction wrote back");
    end

    initial begin
        iStall     = 1'b0;
        dStall     = 1'b0;
        done       = 1'b0;
        progLen    = 0;
        refPc      = 32'h0;
        refNextPc  = 32'h4;
        for (int i = 0; i < memWords; i++) begin
            dataMem[i] = fillWord(i);
            refMem[i]  = fillWord(i);
        end
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = 32'h0;
        end
        buildProgram();
        wait (done);
        repeat (2) @(posedge clk);
        for (int i = 0; i < memWords; i++) begin
            checkEq($sformatf("dataMem[%0d]", i), dataMem[i], refMem[i]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
